//--- Bender.yml
package:
  name: quadrant_decoder

sources:
  - files:
      - source/opcodePkg.sv
      - source/controlPkg.sv
      - source/jumpPairDecoder.sv
      - source/indirectPairDecoder.sv
      - source/incDecDecoder.sv
      - source/immRotateDecoder.sv
      - source/controlMerge.sv
      - source/quadrantDecoder.sv
  - target: test
    files:
      - bench/quadrantDecoderTb.sv

//--- bench/decodeTrace.txt
// opcode step ctrl unsupported, all hex; ctrl is the 36-bit control word, endInstr as top bit.
// The last twelve vectors run back to back.
00 00 800000000 0
08 00 C00000000 0
10 00 080000000 0
18 00 100000000 0
20 00 180000000 0
38 00 180000006 0
01 00 200000000 0
09 00 008200000 0
09 01 808100B01 0
19 02 000000000 0
0A 00 800800080 0
12 00 800000050 0
22 00 300000000 0
03 00 00C020000 0
03 01 80C010001 0
1B 00 015080000 0
1B 01 815040001 0
33 00 00F008000 0
33 01 80F004001 0
04 00 80C013E00 0
27 00 000000000 1
3D 00 814803E00 0
76 00 000000000 1
34 00 380000000 0
3E 00 28000000E 0
07 00 818800B00 0
C3 00 000000000 1
1F 00 830800B00 0
2F 00 838800A00 0
37 00 840000B00 0
3F 00 848000B00 0
FF 00 000000000 1

//--- bench/quadrantDecoderTb.sv
// Reads bench/decodeTrace.txt from the project root; the last BurstLength vectors have no gaps.
`timescale 1ns/100ps

module quadrantDecoderTb;

    localparam int StepWidth = 5;
    localparam int BurstLength = 12;
    localparam logic [7:0] LfsrSeed = 8'd61;

    typedef struct packed {
        opcodePkg::opcodeT    opcode;
        logic [StepWidth-1:0] step;
        controlPkg::controlT  ctrl;
        logic                 unsupported;
    } traceT;

    typedef struct packed {
        logic                valid;
        controlPkg::controlT ctrl;
        logic                unsupported;
    } expectT;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 opValid;
    opcodePkg::opcodeT    opcode;
    logic [StepWidth-1:0] step;
    logic                 ctrlValid;
    controlPkg::controlT  ctrl;
    logic                 unsupported;

    traceT      vectors[$];
    expectT     expected[$]; // One entry per driven cycle, idle included.
    expectT     want;
    logic [7:0] lfsr;
    int         cycles = 0;
    int         validErrors = 0;
    int         ctrlErrors = 0;
    int         unsupportedErrors = 0;
    int         otherErrors = 0;

    quadrantDecoder #(.StepWidth(StepWidth)) quadrantDecoder_i (
        .clk(clk),
        .rstN(rstN),
        .opValid(opValid),
        .opcode(opcode),
        .step(step),
        .ctrlValid(ctrlValid),
        .ctrl(ctrl),
        .unsupported(unsupported)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Fibonacci form with taps 8, 6, 5 and 4.
    function automatic logic [7:0] nextLfsr(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic loadTrace();
        int              fd;
        logic [8*96-1:0] line;
        logic [7:0]      opcodeRaw;
        logic [7:0]      stepRaw;
        logic [35:0]     ctrlRaw;
        logic [3:0]      unsupportedRaw;
        traceT           vec;
        fd = $fopen("bench/decodeTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/decodeTrace.txt.");
            otherErrors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment lines fail to parse.
                if ($sscanf(line, "%h %h %h %h",
                        opcodeRaw, stepRaw, ctrlRaw, unsupportedRaw) == 4) begin
                    vec.opcode = opcodeRaw;
                    vec.step = stepRaw[StepWidth-1:0];
                    vec.ctrl = controlPkg::controlT'(ctrlRaw);
                    vec.unsupported = unsupportedRaw[0];
                    vectors.push_back(vec);
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("The trace file holds no vectors.");
                otherErrors++;
            end
        end
    endtask

    task automatic driveIdle();
        @(posedge clk);
        opValid <= 1'b0; // Opcode stays on the bus, output must still be gated.
        expected.push_back('0);
    endtask

    task automatic driveVector(input traceT vec);
        expectT item;
        @(posedge clk);
        opValid <= 1'b1;
        opcode <= vec.opcode;
        step <= vec.step;
        item.valid = 1'b1;
        item.ctrl = vec.ctrl;
        item.unsupported = vec.unsupported;
        expected.push_back(item);
    endtask

    task automatic compareOutputs(input expectT wanted);
        assert (ctrlValid === wanted.valid) else begin
            $display("Fail ctrlValid: got %h, expected %h at %0t",
                ctrlValid, wanted.valid, $time);
            validErrors++;
        end
        assert (ctrl === wanted.ctrl) else begin
            $display("Fail ctrl: got %h, expected %h at %0t", ctrl, wanted.ctrl, $time);
            ctrlErrors++;
        end
        assert (unsupported === wanted.unsupported) else begin
            $display("Fail unsupported: got %h, expected %h at %0t",
                unsupported, wanted.unsupported, $time);
            unsupportedErrors++;
        end
    endtask

    task automatic printCounts();
        $display("Errors: ctrlValid %0d, ctrl %0d, unsupported %0d, other %0d",
            validErrors, ctrlErrors, unsupportedErrors, otherErrors);
    endtask

    // Outputs at a falling edge belong to the cycle driven two entries back.
    always @(negedge clk) begin
        want = '0;
        if (expected.size() > 1) begin
            want = expected.pop_front();
        end
        compareOutputs(want);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * vectors.size() + 50) begin
            $display("Timeout after %0d cycles, the trace did not finish.", cycles);
            otherErrors++;
            printCounts();
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        opValid = 1'b0;
        opcode = '0;
        step = '0;
        lfsr = LfsrSeed;
        loadTrace();
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < vectors.size(); i++) begin
            if (i < vectors.size() - BurstLength) begin
                lfsr = nextLfsr(lfsr);
                if (lfsr[0]) begin
                    driveIdle();
                end
            end
            driveVector(vectors[i]);
        end
        driveIdle();
        repeat (2) @(posedge clk);
        printCounts();
        if (validErrors + ctrlErrors + unsupportedErrors + otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- list.f
source/opcodePkg.sv
source/controlPkg.sv
source/jumpPairDecoder.sv
source/indirectPairDecoder.sv
source/incDecDecoder.sv
source/immRotateDecoder.sv
source/controlMerge.sv
source/quadrantDecoder.sv
bench/quadrantDecoderTb.sv

//--- source/controlMerge.sv
// One cycle of latency, no back-pressure; expects at most one group word known per opcode.
`timescale 1ns/100ps

module controlMerge (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  opValid,
    input  controlPkg::groupWordT words [4],
    output logic                  ctrlValid,
    output controlPkg::controlT   ctrl,
    output logic                  unsupported
);

    controlPkg::controlT merged;
    logic anyKnown;

    always_comb begin
        merged = '0;
        anyKnown = 1'b0;
        for (int i = 0; i < 4; i++) begin
            merged = controlPkg::controlT'(merged | words[i].ctrl);
            anyKnown = anyKnown | words[i].known;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl <= '0;
            unsupported <= 1'b0;
        end else begin
            ctrlValid <= opValid;
            ctrl <= opValid ? merged : '0;
            unsupported <= opValid && !anyKnown; // Other quadrants and DAA.
        end
    end

    // Group decoders cover disjoint opcode ranges.
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({words[3].known, words[2].known, words[1].known, words[0].known}));

    assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.endInstr && ctrl.seqEntry != controlPkg::seqNone));

    assert property (@(posedge clk) disable iff (!rstN) $onehot0(ctrl.regWrite));

endmodule

//--- source/controlPkg.sv
// Control word for the datapath; regWrite is one-hot in register index order, (HL) bit unused.
package controlPkg;

    typedef enum logic [3:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluRlc,
        aluRrc,
        aluRl,
        aluRr,
        aluCpl,
        aluScf,
        aluCcf
    } aluOpT;

    // Entry points of the instruction sequencer.
    typedef enum logic [2:0] {
        seqNone,
        seqDjnz,
        seqJr,
        seqJrCond,
        seqLdPairImm,
        seqLdRegImm,
        seqLdIndirect,
        seqIncDecMem
    } seqEntryT;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic pv;
        logic n;
        logic c;
    } flagMaskT;

    localparam flagMaskT FlagsHnc = '{s: 1'b0, z: 1'b0, h: 1'b1, pv: 1'b0, n: 1'b1, c: 1'b1};
    localparam flagMaskT FlagsHn = '{s: 1'b0, z: 1'b0, h: 1'b1, pv: 1'b0, n: 1'b1, c: 1'b0};
    localparam flagMaskT FlagsIncDec = '{s: 1'b1, z: 1'b1, h: 1'b1, pv: 1'b1, n: 1'b1, c: 1'b0};

    typedef struct packed {
        logic              endInstr; // Step reset and new M1.
        logic              exAf;
        seqEntryT          seqEntry;
        aluOpT             aluOp;
        logic              aluOne; // Second operand is 1.
        opcodePkg::pairIdxT srcPair;
        logic [7:0]        regWrite;
        logic              spWriteLow;
        logic              spWriteHigh;
        flagMaskT          flagWrite;
        logic              busRead;
        logic              busWrite;
        opcodePkg::pairIdxT addrPair;
        logic [2:0]        target; // Register, pair or condition.
        logic              halfHigh;
    } controlT;

    typedef struct packed {
        logic    known;
        controlT ctrl;
    } groupWordT;

endpackage

//--- source/immRotateDecoder.sv
// Handles x = 0 with z = 6 or 7 only; DAA is not decoded and reads as unknown.
`timescale 1ns/100ps

module immRotateDecoder #(
    parameter int StepWidth = 5
) (
    input  opcodePkg::opcodeT     opcode,
    input  logic [StepWidth-1:0]  step,
    output controlPkg::groupWordT word
);

    logic atFirst;

    assign atFirst = (step == StepWidth'(opcodePkg::stepFirst));

    always_comb begin
        word = '0;
        if (opcode.xyz.x == 2'd0 && opcode.xyz.z[2:1] == 2'd3) begin
            if (!opcode.xyz.z[0]) begin
                word.known = 1'b1;
                if (atFirst) begin
                    word.ctrl.seqEntry = controlPkg::seqLdRegImm;
                    word.ctrl.target = opcode.xyz.y;
                end
            end else if (opcode.xyz.y != 3'd4) begin
                word.known = 1'b1;
                if (atFirst) begin
                    word.ctrl.endInstr = 1'b1;
                    word.ctrl.flagWrite = controlPkg::FlagsHnc;
                    case (opcode.xyz.y)
                        3'd0: word.ctrl.aluOp = controlPkg::aluRlc;
                        3'd1: word.ctrl.aluOp = controlPkg::aluRrc;
                        3'd2: word.ctrl.aluOp = controlPkg::aluRl;
                        3'd3: word.ctrl.aluOp = controlPkg::aluRr;
                        3'd5: begin
                            word.ctrl.aluOp = controlPkg::aluCpl;
                            word.ctrl.flagWrite = controlPkg::FlagsHn; // Carry kept.
                        end
                        3'd6: word.ctrl.aluOp = controlPkg::aluScf;
                        default: word.ctrl.aluOp = controlPkg::aluCcf;
                    endcase
                    // Rotates and CPL write A.
                    word.ctrl.regWrite[opcodePkg::regA] = !opcode.xyz.y[2] || !opcode.xyz.y[1];
                end
            end
        end
    end

endmodule

//--- source/incDecDecoder.sv
// Handles x = 0 with z = 4 or 5 only; INC/DEC (HL) goes to the sequencer.
`timescale 1ns/100ps

module incDecDecoder #(
    parameter int StepWidth = 5
) (
    input  opcodePkg::opcodeT     opcode,
    input  logic [StepWidth-1:0]  step,
    output controlPkg::groupWordT word
);

    logic atFirst;

    assign atFirst = (step == StepWidth'(opcodePkg::stepFirst));

    always_comb begin
        word = '0;
        if (opcode.xyz.x == 2'd0 && opcode.xyz.z[2:1] == 2'd2) begin
            word.known = 1'b1;
            if (atFirst) begin
                if (opcode.xyz.y == opcodePkg::regMem) begin
                    word.ctrl.seqEntry = controlPkg::seqIncDecMem;
                end else begin
                    // z = 5 is DEC.
                    word.ctrl.aluOp = opcode.xyz.z[0] ? controlPkg::aluSub : controlPkg::aluAdd;
                    word.ctrl.aluOne = 1'b1;
                    word.ctrl.regWrite[opcode.xyz.y] = 1'b1;
                    word.ctrl.flagWrite = controlPkg::FlagsIncDec;
                    word.ctrl.endInstr = 1'b1;
                end
            end
        end
    end

endmodule

//--- source/indirectPairDecoder.sv
// Handles x = 0 with z = 2 or 3 only; LD (nn) forms are left to the sequencer.
`timescale 1ns/100ps

module indirectPairDecoder #(
    parameter int StepWidth = 5
) (
    input  opcodePkg::opcodeT     opcode,
    input  logic [StepWidth-1:0]  step,
    output controlPkg::groupWordT word
);

    logic atFirst;
    logic atSecond;
    logic isSp;

    assign atFirst = (step == StepWidth'(opcodePkg::stepFirst));
    assign atSecond = (step == StepWidth'(opcodePkg::stepSecond));
    assign isSp = (opcode.xpqz.p == opcodePkg::pairSp);

    always_comb begin
        word = '0;
        if (opcode.xpqz.x == 2'd0 && opcode.xpqz.z[2:1] == 2'd1) begin
            word.known = 1'b1;
            if (!opcode.xpqz.z[0]) begin
                if (atFirst && !opcode.xpqz.p[1]) begin
                    // LD (BC),A / LD (DE),A and the reverse loads.
                    word.ctrl.addrPair = opcode.xpqz.p;
                    word.ctrl.busWrite = !opcode.xpqz.q;
                    word.ctrl.busRead = opcode.xpqz.q;
                    word.ctrl.regWrite[opcodePkg::regA] = opcode.xpqz.q;
                    word.ctrl.endInstr = 1'b1;
                end else if (atFirst) begin
                    word.ctrl.seqEntry = controlPkg::seqLdIndirect;
                end
            end else if (atFirst || atSecond) begin
                word.ctrl.aluOp = opcode.xpqz.q ? controlPkg::aluSub : controlPkg::aluAdd;
                word.ctrl.aluOne = 1'b1;
                word.ctrl.srcPair = opcode.xpqz.p;
                word.ctrl.halfHigh = atSecond;
                word.ctrl.endInstr = atSecond;
                if (isSp) begin
                    word.ctrl.spWriteLow = atFirst;
                    word.ctrl.spWriteHigh = atSecond;
                end else begin
                    word.ctrl.regWrite[{opcode.xpqz.p, atFirst}] = 1'b1; // Odd index is low byte.
                end
            end
        end
    end

endmodule

//--- source/jumpPairDecoder.sv
// Handles x = 0 with z = 0 or 1 only; relative jumps and LD rr,nn are left to the sequencer.
`timescale 1ns/100ps

module jumpPairDecoder #(
    parameter int StepWidth = 5
) (
    input  opcodePkg::opcodeT     opcode,
    input  logic [StepWidth-1:0]  step,
    output controlPkg::groupWordT word
);

    logic atFirst;
    logic atSecond;

    assign atFirst = (step == StepWidth'(opcodePkg::stepFirst));
    assign atSecond = (step == StepWidth'(opcodePkg::stepSecond));

    always_comb begin
        word = '0;
        if (opcode.xyz.x == 2'd0 && opcode.xyz.z[2:1] == 2'd0) begin
            word.known = 1'b1;
            if (!opcode.xyz.z[0]) begin
                if (atFirst) begin
                    case (opcode.xyz.y)
                        3'd0: word.ctrl.endInstr = 1'b1; // NOP.
                        3'd1: begin
                            word.ctrl.exAf = 1'b1;
                            word.ctrl.endInstr = 1'b1;
                        end
                        3'd2: word.ctrl.seqEntry = controlPkg::seqDjnz;
                        3'd3: word.ctrl.seqEntry = controlPkg::seqJr;
                        default: begin
                            word.ctrl.seqEntry = controlPkg::seqJrCond;
                            word.ctrl.target = {1'b0, opcode.xyz.y[1:0]}; // y - 4.
                        end
                    endcase
                end
            end else if (!opcode.xpqz.q) begin
                if (atFirst) begin
                    word.ctrl.seqEntry = controlPkg::seqLdPairImm;
                    word.ctrl.target = {1'b0, opcode.xpqz.p};
                end
            end else if (atFirst || atSecond) begin
                // ADD HL,rr writes the low byte first.
                word.ctrl.aluOp = controlPkg::aluAdd;
                word.ctrl.srcPair = opcode.xpqz.p;
                if (atFirst) begin
                    word.ctrl.regWrite[opcodePkg::regL] = 1'b1;
                end else begin
                    word.ctrl.halfHigh = 1'b1;
                    word.ctrl.regWrite[opcodePkg::regH] = 1'b1;
                    word.ctrl.flagWrite = controlPkg::FlagsHnc;
                    word.ctrl.endInstr = 1'b1;
                end
            end
        end
    end

endmodule

//--- source/opcodePkg.sv
// Opcode views follow the Z80 x/y/z and x/p/q/z split; step values count from the opcode fetch.
package opcodePkg;

    // Register index as encoded in y and in the low/high halves of a pair.
    typedef enum logic [2:0] {
        regB,
        regC,
        regD,
        regE,
        regH,
        regL,
        regMem,
        regA
    } regIdxT;

    typedef enum logic [1:0] {
        pairBc,
        pairDe,
        pairHl,
        pairSp
    } pairIdxT;

    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y; // 8-bit register or condition.
        logic [2:0] z;
    } opcodeXyzT;

    typedef struct packed {
        logic [1:0] x;
        pairIdxT    p;
        logic       q;
        logic [2:0] z;
    } opcodeXpqzT;

    // Same byte, decoded by y or by p and q.
    typedef union packed {
        opcodeXyzT  xyz;
        opcodeXpqzT xpqz;
    } opcodeT;

    // Named steps of the instruction; later steps belong to the sequencer.
    typedef enum int unsigned {
        stepFirst  = 0,
        stepSecond = 1
    } stepT;

endpackage

//--- source/quadrantDecoder.sv
// Decodes only the x = 0 quadrant; step must be held by an external step counter.
`timescale 1ns/100ps

module quadrantDecoder #(
    parameter int StepWidth = 5
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 opValid,
    input  opcodePkg::opcodeT    opcode,
    input  logic [StepWidth-1:0] step,
    output logic                 ctrlValid,
    output controlPkg::controlT  ctrl,
    output logic                 unsupported
);

    controlPkg::groupWordT groupWords [4]; // Indexed by opcode bits 2:1.

    jumpPairDecoder #(.StepWidth(StepWidth)) jumpPairDecoder_i (
        .opcode(opcode),
        .step(step),
        .word(groupWords[0])
    );

    indirectPairDecoder #(.StepWidth(StepWidth)) indirectPairDecoder_i (
        .opcode(opcode),
        .step(step),
        .word(groupWords[1])
    );

    incDecDecoder #(.StepWidth(StepWidth)) incDecDecoder_i (
        .opcode(opcode),
        .step(step),
        .word(groupWords[2])
    );

    immRotateDecoder #(.StepWidth(StepWidth)) immRotateDecoder_i (
        .opcode(opcode),
        .step(step),
        .word(groupWords[3])
    );

    controlMerge controlMerge_i (
        .clk(clk),
        .rstN(rstN),
        .opValid(opValid),
        .words(groupWords),
        .ctrlValid(ctrlValid),
        .ctrl(ctrl),
        .unsupported(unsupported)
    );

endmodule
